// File: Bender.yml
package:
  name: mini_core

sources:
  - verilog/isa_pkg.sv
  - verilog/core_pkg.sv
  - verilog/master_ctrl.sv
  - verilog/seq_fsm.sv
  - verilog/instr_counter.sv
  - verilog/alu.sv
  - verilog/reg_file.sv
  - verilog/mem_array.sv
  - verilog/mini_core.sv
  - target: test
    files:
      - testbench/clk_gen.sv
      - testbench/tb_mini_core.sv

// File: compile.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/master_ctrl.sv
verilog/seq_fsm.sv
verilog/instr_counter.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/mem_array.sv
verilog/mini_core.sv
testbench/clk_gen.sv
testbench/tb_mini_core.sv

// File: testbench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
    parameter real PERIOD = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// File: testbench/tb_mini_core.sv
`timescale 1ns/100ps

module tb_mini_core import isa_pkg::*, core_pkg::*; ();

    localparam int TIMEOUT = 4000;

    logic   clk;
    logic   rst;
    logic   start;
    logic   load_en;
    word_t  load_addr;
    word_t  load_data;
    word_t  dbg_addr;
    word_t  dbg_data;
    logic   halted;
    logic   error;
    count_t retired;

    word_t  prog [256];
    int     prog_len;
    word_t  exp_mem [256];
    bit     exp_valid [256];
    int     n_tests;
    int     n_checks;
    int     n_errors;

    clk_gen clk_gen_inst (.clk(clk));

    mini_core mini_core_inst (
        .clk(clk), .rst(rst), .start(start), .load_en(load_en),
        .load_addr(load_addr), .load_data(load_data), .dbg_addr(dbg_addr),
        .dbg_data(dbg_data), .halted(halted), .error(error), .retired(retired)
    );

    function automatic word_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rd, logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic word_t enc_r(opcode_t op, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    func_t fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic word_t enc_b(opcode_t op, reg_addr_t rs, logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic word_t rotl(word_t x, logic [3:0] s);
        return (s == 0) ? x : ((x << s) | (x >> (16 - s)));
    endfunction

    function automatic word_t rotr(word_t x, logic [3:0] s);
        return (s == 0) ? x : ((x >> s) | (x << (16 - s)));
    endfunction

    task automatic emit(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // Instruction-level model of the ISA that runs the program in prog
    function automatic void ref_model(output count_t n_ret, output logic flt);
        word_t r [8];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t ea;
        word_t i8s;
        word_t npc;
        opcode_t op;
        bit done;
        for (int i = 0; i < 8; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = '0;
            exp_valid[i] = 1'b0;
        end
        pc = '0;
        n_ret = '0;
        flt = 1'b0;
        done = 1'b0;
        for (int step = 0; step < 2000 && !done; step++) begin
            ins = prog[pc[7:0]];
            op = ins[15:11];
            a = r[ins[10:8]];
            b = r[ins[7:5]];
            ea = a + {{11{ins[4]}}, ins[4:0]};
            i8s = {{8{ins[7]}}, ins[7:0]};
            npc = pc + 16'd1;
            case (op)
                OP_HALT:  done = 1'b1;
                OP_NOP:   ;
                OP_ADDI:  r[ins[7:5]] = ea;
                OP_SUBI:  r[ins[7:5]] = {{11{ins[4]}}, ins[4:0]} - a;
                OP_XORI:  r[ins[7:5]] = a ^ {11'd0, ins[4:0]};
                OP_ANDNI: r[ins[7:5]] = a & ~{11'd0, ins[4:0]};
                OP_ROLI:  r[ins[7:5]] = rotl(a, ins[3:0]);
                OP_SLLI:  r[ins[7:5]] = a << ins[3:0];
                OP_RORI:  r[ins[7:5]] = rotr(a, ins[3:0]);
                OP_SRLI:  r[ins[7:5]] = a >> ins[3:0];
                OP_ST, OP_STU: begin
                    exp_mem[ea[7:0]] = b;
                    exp_valid[ea[7:0]] = 1'b1;
                    if (op == OP_STU) r[ins[10:8]] = ea;
                end
                OP_LD: r[ins[7:5]] = exp_mem[ea[7:0]];
                OP_ADD: begin
                    case (ins[1:0])
                        FN_ADD:  r[ins[4:2]] = a + b;
                        FN_SUB:  r[ins[4:2]] = b - a;
                        FN_XOR:  r[ins[4:2]] = a ^ b;
                        default: r[ins[4:2]] = a & ~b;
                    endcase
                end
                OP_ROL: begin
                    case (ins[1:0])
                        FN_ROL:  r[ins[4:2]] = rotl(a, b[3:0]);
                        FN_SLL:  r[ins[4:2]] = a << b[3:0];
                        FN_ROR:  r[ins[4:2]] = rotr(a, b[3:0]);
                        default: r[ins[4:2]] = a >> b[3:0];
                    endcase
                end
                OP_BEQZ: if (a == 0) npc = npc + i8s;
                OP_BNEZ: if (a != 0) npc = npc + i8s;
                OP_BLTZ: if (a[15]) npc = npc + i8s;
                OP_BGEZ: if (!a[15]) npc = npc + i8s;
                OP_LBI:  r[ins[10:8]] = i8s;
                OP_SLBI: r[ins[10:8]] = {a[7:0], ins[7:0]};
                OP_J, OP_JAL: begin
                    if (op == OP_JAL) r[7] = npc;
                    npc = npc + {{5{ins[10]}}, ins[10:0]};
                end
                OP_JR, OP_JALR: begin
                    if (op == OP_JALR) r[7] = npc;
                    npc = a + i8s;
                end
                default: begin
                    flt = 1'b1;
                    done = 1'b1;
                end
            endcase
            if (!done) begin
                n_ret++;
                pc = npc;
            end
        end
    endfunction

    task automatic check_word(string name, word_t addr, word_t exp);
        @(negedge clk);
        dbg_addr = addr;
        @(posedge clk);
        n_checks++;
        if (dbg_data !== exp) begin
            $display("error %s: mem[%0d] expected %h actual %h", name, addr, exp, dbg_data);
            n_errors++;
        end
    endtask

    task automatic check_count(string name, count_t exp, count_t act);
        n_checks++;
        if (act !== exp) begin
            $display("error %s: retired expected %0d actual %0d", name, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            $display("error %s: error flag expected %b actual %b", name, exp, act);
            n_errors++;
        end
    endtask

    // Reset, load, start, wait for halt, then compare with the model
    task automatic run_test(string name);
        count_t exp_ret;
        logic   exp_flt;
        int     errs_before;
        bit     done;
        errs_before = n_errors;
        n_tests++;
        ref_model(exp_ret, exp_flt);
        @(negedge clk);
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            load_en = 1'b1;
            load_addr = word_t'(i);
            load_data = prog[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        done = 1'b0;
        for (int cyc = 0; cyc < TIMEOUT && !done; cyc++) begin
            if (halted) done = 1'b1;
            else @(negedge clk);
        end
        if (!done) begin
            $display("Test %s timed out waiting for the core to halt", name);
            n_errors++;
        end else begin
            check_flag(name, exp_flt, error);
            check_count(name, exp_ret, retired);
            for (int i = 0; i < 256; i++) begin
                if (exp_valid[i]) check_word(name, word_t'(i), exp_mem[i]);
            end
        end
        if (n_errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, n_errors - errs_before);
        prog_len = 0;
    endtask

    task automatic test_arith();
        emit(enc_b(OP_LBI, 1, 8'($urandom)));
        emit(enc_b(OP_LBI, 2, 8'($urandom)));
        emit(enc_r(OP_ADD, 1, 2, 3, FN_ADD));
        emit(enc_r(OP_SUB, 1, 2, 4, FN_SUB));
        emit(enc_r(OP_XOR, 1, 2, 5, FN_XOR));
        emit(enc_r(OP_ANDN, 1, 2, 6, FN_ANDN));
        for (int i = 0; i < 4; i++) emit(enc_i(OP_ST, 0, reg_addr_t'(3 + i), 5'(i)));
        emit(enc_i(OP_ADDI, 1, 3, 5'($urandom)));
        emit(enc_i(OP_SUBI, 1, 4, 5'($urandom)));
        emit(enc_i(OP_XORI, 2, 5, 5'($urandom)));
        emit(enc_i(OP_ANDNI, 2, 6, 5'($urandom)));
        for (int i = 0; i < 4; i++) emit(enc_i(OP_ST, 0, reg_addr_t'(3 + i), 5'(4 + i)));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test("arith");
    endtask

    task automatic test_shift();
        opcode_t ops [4];
        func_t   fns [4];
        ops = '{OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};
        fns = '{FN_ROL, FN_SLL, FN_ROR, FN_SRL};
        emit(enc_b(OP_LBI, 1, 8'($urandom)));
        emit(enc_b(OP_SLBI, 1, 8'($urandom)));
        emit(enc_b(OP_LBI, 2, 8'($urandom)));
        for (int i = 0; i < 4; i++) begin
            emit(enc_i(ops[i], 1, 3, 5'($urandom)));
            emit(enc_i(OP_ST, 0, 3, 5'(i)));
            emit(enc_r(OP_ROL, 1, 2, 4, fns[i]));
            emit(enc_i(OP_ST, 0, 4, 5'(4 + i)));
        end
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test("shift");
    endtask

    task automatic test_mem();
        emit(enc_b(OP_LBI, 1, 8'($urandom)));
        emit(enc_b(OP_LBI, 2, 8'd8));
        emit(enc_i(OP_ST, 2, 1, 5'd0));
        emit(enc_i(OP_LD, 2, 3, 5'd0));
        emit(enc_i(OP_ADDI, 3, 3, 5'd1));
        emit(enc_i(OP_STU, 2, 3, 5'd2));       // r2 becomes 10
        emit(enc_i(OP_ST, 2, 1, 5'd1));        // Lands at 11
        emit(enc_i(OP_ST, 0, 2, 5'd3));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test("mem");
    endtask

    task automatic test_branch();
        opcode_t bops [8];
        reg_addr_t brs [8];
        bops = '{OP_BEQZ, OP_BEQZ, OP_BNEZ, OP_BNEZ, OP_BLTZ, OP_BLTZ, OP_BGEZ, OP_BGEZ};
        brs = '{1, 3, 3, 1, 2, 3, 3, 2};
        emit(enc_b(OP_LBI, 1, 8'd0));
        emit(enc_b(OP_LBI, 2, 8'hfd));
        emit(enc_b(OP_LBI, 3, 8'd5));
        emit(enc_b(OP_LBI, 4, 8'h11));         // Marker
        emit(enc_b(OP_LBI, 6, 8'h5a));         // Background
        for (int i = 0; i < 13; i++) emit(enc_i(OP_ST, 0, 6, 5'(i)));
        for (int i = 0; i < 8; i++) begin
            emit(enc_b(bops[i], brs[i], 8'd1));
            emit(enc_i(OP_ST, 0, 4, 5'(i)));
        end
        emit({OP_J, 11'd1});
        emit(enc_i(OP_ST, 0, 4, 5'd8));
        emit({OP_JAL, 11'd1});
        emit(enc_i(OP_ST, 0, 4, 5'd9));
        emit(enc_i(OP_ST, 0, 7, 5'd10));
        emit(enc_b(OP_LBI, 5, 8'(prog_len + 3)));
        emit(enc_b(OP_JR, 5, 8'd0));
        emit(enc_i(OP_ST, 0, 4, 5'd11));
        emit(enc_b(OP_LBI, 5, 8'(prog_len + 3)));
        emit(enc_b(OP_JALR, 5, 8'd0));
        emit(enc_i(OP_ST, 0, 4, 5'd11));
        emit(enc_i(OP_ST, 0, 7, 5'd12));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test("branch");
    endtask

    task automatic test_illegal();
        emit(enc_b(OP_LBI, 1, 8'($urandom)));
        emit(enc_i(OP_ST, 0, 1, 5'd0));
        emit(enc_i(OP_ADDI, 1, 2, 5'($urandom)));
        emit(enc_i(OP_ST, 0, 2, 5'd1));
        emit({5'b11100, 11'd0});               // SEQ is not supported
        emit(enc_i(OP_ST, 0, 1, 5'd2));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test("illegal");
    endtask

    task automatic test_random(int idx);
        bit        stored [16];
        int        kind;
        logic [4:0] addr;
        reg_addr_t rs;
        reg_addr_t rd;
        for (int i = 0; i < 16; i++) stored[i] = 1'b0;
        for (int i = 1; i < 8; i++) emit(enc_b(OP_LBI, reg_addr_t'(i), 8'($urandom)));
        for (int i = 0; i < 24; i++) begin
            kind = $urandom_range(0, 9);
            rs = reg_addr_t'($urandom_range(1, 7));
            rd = reg_addr_t'($urandom_range(1, 7));
            addr = 5'($urandom_range(0, 15));
            if (kind == 9 && !stored[addr]) kind = 0;
            case (kind)
                0, 1, 2, 3: emit(enc_r(OP_ADD, rs, rd, reg_addr_t'($urandom_range(1, 7)),
                                       func_t'(kind)));
                4: emit(enc_i(OP_ADDI, rs, rd, 5'($urandom)));
                5: emit(enc_i(OP_SUBI, rs, rd, 5'($urandom)));
                6: emit(enc_i(OP_XORI, rs, rd, 5'($urandom)));
                7: emit(enc_i(OP_ANDNI, rs, rd, 5'($urandom)));
                8: begin
                    emit(enc_i(OP_ST, 0, rd, addr));
                    stored[addr] = 1'b1;
                end
                default: emit(enc_i(OP_LD, 0, rd, addr));
            endcase
        end
        for (int i = 1; i < 8; i++) emit(enc_i(OP_ST, 0, reg_addr_t'(i), 5'(16 - i)));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test($sformatf("random_%0d", idx));
    endtask

    initial begin
        void'($urandom(32'h8ccf4107));
        rst = 1'b1;
        start = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr = '0;
        prog_len = 0;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < 256; i++) prog[i] = '0;
        test_arith();
        test_shift();
        test_mem();
        test_branch();
        test_illegal();
        for (int i = 0; i < 4; i++) test_random(i);
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/100ps

module alu import isa_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  opcode_t opcode,
    input  func_t   func,
    input  logic    inv_a,
    input  logic    inv_b,
    input  logic    cin,
    output word_t   result
);

    word_t       a_i;
    word_t       b_i;
    word_t       sum;
    logic [3:0]  amt;
    logic [31:0] dbl;
    logic [31:0] rot_l;
    logic [31:0] rot_r;
    logic        r_fmt;
    func_t       sub_op;

    assign a_i   = inv_a ? ~a : a;
    assign b_i   = inv_b ? ~b : b;
    assign sum   = a_i + b_i + {15'd0, cin};
    assign amt   = b[3:0];
    assign dbl   = {a, a};
    assign rot_l = dbl << amt;
    assign rot_r = dbl >> amt;

    // R-format takes the op from func, I-format from the opcode low bits
    assign r_fmt  = (opcode == OP_ADD) || (opcode == OP_ROL);
    assign sub_op = r_fmt ? func : opcode[1:0];

    always_comb begin
        if (opcode == OP_LBI) begin
            result = b;
        end else if (opcode == OP_SLBI) begin
            result = {a[7:0], 8'h00} | b;
        end else if (opcode == OP_ROL || opcode[4:2] == 3'b101) begin
            case (sub_op)
                FN_ROL:  result = rot_l[31:16];
                FN_SLL:  result = a << amt;
                FN_ROR:  result = rot_r[15:0];
                default: result = a >> amt;     // SRL
            endcase
        end else if (opcode == OP_ADD || opcode[4:2] == 3'b010) begin
            case (sub_op)
                FN_XOR:  result = a_i ^ b_i;
                FN_ANDN: result = a_i & b_i;    // B already inverted
                default: result = sum;
            endcase
        end else begin
            result = sum;                       // Memory address
        end
    end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

    localparam int COUNT_W = 16;

    typedef logic [COUNT_W-1:0] count_t;

    typedef logic [2:0] alu_src_t;
    localparam alu_src_t SRC_REG2   = 3'b000;
    localparam alu_src_t SRC_IMM5_S = 3'b001;
    localparam alu_src_t SRC_IMM5_Z = 3'b010;
    localparam alu_src_t SRC_IMM8_S = 3'b011;
    localparam alu_src_t SRC_IMM8_Z = 3'b100;
    localparam alu_src_t SRC_ZERO   = 3'b101;
    localparam alu_src_t SRC_DC     = 3'b110; // Don't care

    typedef logic [1:0] reg_dst_t;
    localparam reg_dst_t DST_B42  = 2'b00;
    localparam reg_dst_t DST_B75  = 2'b01;
    localparam reg_dst_t DST_B108 = 2'b10;
    localparam reg_dst_t DST_R7   = 2'b11;

    typedef logic [1:0] pc_src_t;
    localparam pc_src_t PC_SEQ = 2'b00;
    localparam pc_src_t PC_BR  = 2'b01;
    localparam pc_src_t PC_JD  = 2'b10; // pc+1 plus disp11
    localparam pc_src_t PC_JR  = 2'b11; // Rs plus disp8

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, WB, HALT, FAULT} core_state_t;

endpackage

// File: verilog/instr_counter.sv
`timescale 1ns/100ps

module instr_counter import isa_pkg::*, core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    wb_en,
    input  pc_src_t pc_src,
    input  func_t   cond,
    input  word_t   rs_val,
    input  word_t   disp8,
    input  word_t   disp11,
    output word_t   pc,
    output word_t   pc_next_seq,
    output count_t  retired
);

    logic  taken;
    word_t pc_next;

    assign pc_next_seq = pc + 16'd1;

    always_comb begin
        case (cond)
            2'b00:   taken = (rs_val == '0);    // BEQZ
            2'b01:   taken = (rs_val != '0);    // BNEZ
            2'b10:   taken = rs_val[15];        // BLTZ
            default: taken = ~rs_val[15];       // BGEZ
        endcase
    end

    always_comb begin
        case (pc_src)
            PC_BR:   pc_next = taken ? pc_next_seq + disp8 : pc_next_seq;
            PC_JD:   pc_next = pc_next_seq + disp11;
            PC_JR:   pc_next = rs_val + disp8;
            default: pc_next = pc_next_seq;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            retired <= '0;
        end else if (wb_en) begin
            pc      <= pc_next;
            retired <= retired + 1'b1;
        end
    end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [1:0]  func_t;

    localparam opcode_t OP_HALT  = 5'b00000;
    localparam opcode_t OP_NOP   = 5'b00001;
    localparam opcode_t OP_ADDI  = 5'b01000;
    localparam opcode_t OP_SUBI  = 5'b01001;
    localparam opcode_t OP_XORI  = 5'b01010;
    localparam opcode_t OP_ANDNI = 5'b01011;
    localparam opcode_t OP_ROLI  = 5'b10100;
    localparam opcode_t OP_SLLI  = 5'b10101;
    localparam opcode_t OP_RORI  = 5'b10110;
    localparam opcode_t OP_SRLI  = 5'b10111;
    localparam opcode_t OP_ST    = 5'b10000;
    localparam opcode_t OP_LD    = 5'b10001;
    localparam opcode_t OP_STU   = 5'b10011;
    localparam opcode_t OP_ADD   = 5'b11011; // R-format arithmetic group
    localparam opcode_t OP_SUB   = 5'b11011;
    localparam opcode_t OP_XOR   = 5'b11011;
    localparam opcode_t OP_ANDN  = 5'b11011;
    localparam opcode_t OP_ROL   = 5'b11010; // R-format shift group
    localparam opcode_t OP_SLL   = 5'b11010;
    localparam opcode_t OP_ROR   = 5'b11010;
    localparam opcode_t OP_SRL   = 5'b11010;
    localparam opcode_t OP_BEQZ  = 5'b01100;
    localparam opcode_t OP_BNEZ  = 5'b01101;
    localparam opcode_t OP_BLTZ  = 5'b01110;
    localparam opcode_t OP_BGEZ  = 5'b01111;
    localparam opcode_t OP_LBI   = 5'b11000;
    localparam opcode_t OP_SLBI  = 5'b10010;
    localparam opcode_t OP_J     = 5'b00100;
    localparam opcode_t OP_JR    = 5'b00101;
    localparam opcode_t OP_JAL   = 5'b00110;
    localparam opcode_t OP_JALR  = 5'b00111;

    localparam func_t FN_ADD  = 2'b00;
    localparam func_t FN_SUB  = 2'b01;
    localparam func_t FN_XOR  = 2'b10;
    localparam func_t FN_ANDN = 2'b11;
    localparam func_t FN_ROL  = 2'b00;
    localparam func_t FN_SLL  = 2'b01;
    localparam func_t FN_ROR  = 2'b10;
    localparam func_t FN_SRL  = 2'b11;

endpackage

// File: verilog/master_ctrl.sv
`timescale 1ns/100ps

module master_ctrl import isa_pkg::*, core_pkg::*; (
    input  opcode_t  opcode,
    input  func_t    func,
    output alu_src_t alu_src,
    output logic     mem_write,
    output logic     reg_write,
    output logic     mem_to_reg,
    output reg_dst_t reg_dst,
    output logic     inv_a,
    output logic     inv_b,
    output logic     cin,
    output logic     dump,
    output logic     err,
    output pc_src_t  pc_src
);

    always_comb begin
        alu_src    = SRC_DC;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_dst    = DST_B75;
        inv_a      = 1'b0;
        inv_b      = 1'b0;
        cin        = 1'b0;
        dump       = 1'b0;
        err        = 1'b0;
        pc_src     = PC_SEQ;
        case (opcode)
            OP_HALT: dump = 1'b1;
            OP_NOP: ;
            OP_ADDI: begin
                alu_src   = SRC_IMM5_S;
                reg_write = 1'b1;
            end
            OP_SUBI: begin              // imm minus Rs
                alu_src   = SRC_IMM5_S;
                reg_write = 1'b1;
                inv_a     = 1'b1;
                cin       = 1'b1;
            end
            OP_XORI: begin
                alu_src   = SRC_IMM5_Z;
                reg_write = 1'b1;
            end
            OP_ANDNI: begin
                alu_src   = SRC_IMM5_Z;
                reg_write = 1'b1;
                inv_b     = 1'b1;
            end
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                alu_src   = SRC_IMM5_Z;
                reg_write = 1'b1;
            end
            OP_ST: begin
                alu_src   = SRC_IMM5_S;
                mem_write = 1'b1;
                reg_dst   = DST_B108;   // Don't care
            end
            OP_LD: begin
                alu_src    = SRC_IMM5_S;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_STU: begin               // Address written back to Rs
                alu_src   = SRC_IMM5_S;
                mem_write = 1'b1;
                reg_write = 1'b1;
                reg_dst   = DST_B108;
            end
            OP_ADD: begin               // ADD, SUB, XOR, ANDN
                alu_src   = SRC_REG2;
                reg_write = 1'b1;
                reg_dst   = DST_B42;
                inv_a     = (func == FN_SUB);
                inv_b     = (func == FN_ANDN);
                cin       = (func == FN_SUB);
            end
            OP_ROL: begin               // ROL, SLL, ROR, SRL
                alu_src   = SRC_REG2;
                reg_write = 1'b1;
                reg_dst   = DST_B42;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                alu_src = SRC_ZERO;
                reg_dst = DST_B108;
                inv_b   = 1'b1;
                cin     = 1'b1;
                pc_src  = PC_BR;
            end
            OP_LBI: begin
                alu_src   = SRC_IMM8_S;
                reg_write = 1'b1;
                reg_dst   = DST_B108;
            end
            OP_SLBI: begin
                alu_src   = SRC_IMM8_Z;
                reg_write = 1'b1;
                reg_dst   = DST_B108;
            end
            OP_J:  pc_src = PC_JD;
            OP_JR: pc_src = PC_JR;
            OP_JAL: begin
                reg_write = 1'b1;
                reg_dst   = DST_R7;
                pc_src    = PC_JD;
            end
            OP_JALR: begin
                reg_write = 1'b1;
                reg_dst   = DST_R7;
                pc_src    = PC_JR;
            end
            default: err = 1'b1;        // BTR, set ops, siic, rti
        endcase
    end

endmodule

// File: verilog/mem_array.sv
`timescale 1ns/100ps

module mem_array import isa_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic  clk,
    input  logic  we,
    input  word_t waddr,
    input  word_t wdata,
    input  word_t raddr,
    output word_t rdata,
    input  word_t dbg_addr,
    output word_t dbg_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[ADDR_W-1:0]] <= wdata;
        end
    end

    assign rdata    = mem[raddr[ADDR_W-1:0]];
    assign dbg_data = mem[dbg_addr[ADDR_W-1:0]];   // Second read port

endmodule

// File: verilog/mini_core.sv
`timescale 1ns/100ps

module mini_core import isa_pkg::*, core_pkg::*; #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   load_en,
    input  word_t  load_addr,
    input  word_t  load_data,
    input  word_t  dbg_addr,
    output word_t  dbg_data,
    output logic   halted,
    output logic   error,
    output count_t retired
);

    core_state_t state;
    logic        fetch_en;
    logic        exec_en;
    logic        wb_en;
    word_t       ir;
    word_t       imem_rdata;
    opcode_t     opcode;
    func_t       func;
    alu_src_t    alu_src;
    logic        mem_write;
    logic        reg_write;
    logic        mem_to_reg;
    reg_dst_t    reg_dst;
    logic        inv_a;
    logic        inv_b;
    logic        cin;
    logic        dump;
    logic        err;
    pc_src_t     pc_src;
    word_t       pc;
    word_t       pc_next_seq;
    word_t       rdata1;
    word_t       rdata2;
    word_t       imm8_s;
    word_t       disp11;
    word_t       alu_b;
    word_t       alu_res;
    word_t       alu_q;
    word_t       dmem_rdata;
    word_t       wb_data;
    reg_addr_t   wr_addr;
    logic        is_link;

    assign opcode = ir[15:11];
    assign func   = ir[1:0];
    assign imm8_s = {{8{ir[7]}}, ir[7:0]};
    assign disp11 = {{5{ir[10]}}, ir[10:0]};

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            ir <= imem_rdata;
        end
        if (exec_en) begin
            alu_q <= alu_res;
        end
    end

    always_comb begin
        case (alu_src)
            SRC_REG2:   alu_b = rdata2;
            SRC_IMM5_S: alu_b = {{11{ir[4]}}, ir[4:0]};
            SRC_IMM5_Z: alu_b = {11'd0, ir[4:0]};
            SRC_IMM8_S: alu_b = imm8_s;
            SRC_IMM8_Z: alu_b = {8'd0, ir[7:0]};
            default:    alu_b = '0;
        endcase
    end

    always_comb begin
        case (reg_dst)
            DST_B42:  wr_addr = ir[4:2];
            DST_B75:  wr_addr = ir[7:5];
            DST_B108: wr_addr = ir[10:8];
            default:  wr_addr = 3'd7;
        endcase
    end

    assign is_link = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign wb_data = is_link ? pc_next_seq : (mem_to_reg ? dmem_rdata : alu_q);

    seq_fsm seq_fsm_inst (
        .clk(clk), .rst(rst), .start(start), .dump(dump), .err(err),
        .state(state), .fetch_en(fetch_en), .exec_en(exec_en), .wb_en(wb_en),
        .halted(halted), .error(error)
    );

    master_ctrl master_ctrl_inst (
        .opcode(opcode), .func(func), .alu_src(alu_src), .mem_write(mem_write),
        .reg_write(reg_write), .mem_to_reg(mem_to_reg), .reg_dst(reg_dst),
        .inv_a(inv_a), .inv_b(inv_b), .cin(cin), .dump(dump), .err(err),
        .pc_src(pc_src)
    );

    instr_counter instr_counter_inst (
        .clk(clk), .rst(rst), .wb_en(wb_en), .pc_src(pc_src), .cond(opcode[1:0]),
        .rs_val(rdata1), .disp8(imm8_s), .disp11(disp11), .pc(pc),
        .pc_next_seq(pc_next_seq), .retired(retired)
    );

    alu alu_inst (
        .a(rdata1), .b(alu_b), .opcode(opcode), .func(func),
        .inv_a(inv_a), .inv_b(inv_b), .cin(cin), .result(alu_res)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst(rst), .we(wb_en && reg_write), .waddr(wr_addr),
        .wdata(wb_data), .raddr1(ir[10:8]), .raddr2(ir[7:5]),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    // Program load only while idle
    mem_array #(.ADDR_W(IMEM_AW)) imem_inst (
        .clk(clk), .we(load_en && (state == IDLE)), .waddr(load_addr),
        .wdata(load_data), .raddr(pc), .rdata(imem_rdata),
        .dbg_addr('0), .dbg_data()
    );

    // Write address is live in EXEC, LD reads with the held result in WB
    mem_array #(.ADDR_W(DMEM_AW)) dmem_inst (
        .clk(clk), .we(exec_en && mem_write), .waddr(alu_res),
        .wdata(rdata2), .raddr(alu_q), .rdata(dmem_rdata),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file import isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: verilog/seq_fsm.sv
`timescale 1ns/100ps

module seq_fsm import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        dump,
    input  logic        err,
    output core_state_t state,
    output logic        fetch_en,
    output logic        exec_en,
    output logic        wb_en,
    output logic        halted,
    output logic        error
);

    core_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:  if (start) state_next = FETCH;
            FETCH: state_next = EXEC;
            EXEC: begin
                if (err) begin
                    state_next = FAULT;
                end else if (dump) begin
                    state_next = HALT;
                end else begin
                    state_next = WB;
                end
            end
            WB:      state_next = FETCH;
            default: state_next = state;    // HALT and FAULT hold
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign fetch_en = (state == FETCH);
    assign exec_en  = (state == EXEC);
    assign wb_en    = (state == WB);
    assign halted   = (state == HALT) || (state == FAULT);
    assign error    = (state == FAULT);

endmodule
